// ==== if_axi_pkg.sv ====
package if_axi_pkg;

  // read channel widths
  localparam int AXI_ADDR_W = 64;
  localparam int AXI_DATA_W = 64;

  // instruction memory geometry, one 64-bit word per entry
  localparam int IMEM_WORDS = 24;
  localparam logic [AXI_ADDR_W-1:0] IMEM_BASE  = if_cpu_pkg::RESET_PC;
  localparam logic [AXI_ADDR_W-1:0] IMEM_BYTES = AXI_ADDR_W'(8 * IMEM_WORDS);
  localparam int IMEM_IDX_W = $clog2(IMEM_WORDS);

  // cycles from AR accept to R valid
  localparam int IMEM_LAT   = 2;
  localparam int IMEM_CNT_W = $clog2(IMEM_LAT + 1);

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // read address channel, ready runs the other way
  typedef struct packed {
    logic                  valid;
    logic [AXI_ADDR_W-1:0] addr;
  } axi_ar_t;

  // read data channel, single beat
  typedef struct packed {
    logic                  valid;
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_r_t;

endpackage

// ==== if_axi_rd_master.sv ====
`timescale 1ns/1ps

module if_axi_rd_master
  import if_axi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic [AXI_ADDR_W-1:0] addr_i,
  output axi_ar_t               ar_o,
  input  logic                  ar_ready_i,
  input  axi_r_t                r_i,
  output logic                  r_ready_o,
  output logic                  rd_done_o,
  output logic [AXI_DATA_W-1:0] rd_data_o,
  output axi_resp_e             rd_resp_o
);

  // AR raised, not yet accepted
  logic ar_pend_q;
  // AR accepted, waiting for the single R beat
  logic r_pend_q;
  logic [AXI_ADDR_W-1:0] addr_q;

  logic ar_fire;
  logic r_fire;
  logic idle;

  assign idle    = !ar_pend_q && !r_pend_q;
  assign ar_fire = ar_pend_q && ar_ready_i;
  assign r_fire  = r_pend_q && r_i.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_pend_q <= 1'b0;
      r_pend_q  <= 1'b0;
    end else begin
      if (req_i && idle) begin
        ar_pend_q <= 1'b1;
      end else if (ar_fire) begin
        ar_pend_q <= 1'b0;
      end
      if (ar_fire) begin
        r_pend_q <= 1'b1;
      end else if (r_fire) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  // doubleword aligned, held stable while valid is up
  always_ff @(posedge clk) begin
    if (req_i && idle) begin
      addr_q <= {addr_i[AXI_ADDR_W-1:3], 3'b000};
    end
  end

  assign ar_o.valid = ar_pend_q;
  assign ar_o.addr  = addr_q;

  // ready for the whole response window
  assign r_ready_o = r_pend_q;

  // beat passed straight through in the accept cycle
  assign rd_done_o = r_fire;
  assign rd_data_o = r_i.data;
  assign rd_resp_o = r_i.resp;

endmodule

// ==== if_cpu_pkg.sv ====
package if_cpu_pkg;

  // core side address and instruction widths
  localparam int PC_W   = 64;
  localparam int INST_W = 32;

  // addi x0, x0, 0
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // first fetch address out of reset
  localparam logic [PC_W-1:0] RESET_PC = 64'h0000_0000_8000_0000;

  // fetch control states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    REQ  = 2'b01,
    WAIT = 2'b10,
    HOLD = 2'b11
  } fetch_state_e;

  // redirect pulse from jump, branch or jalr
  typedef struct packed {
    logic            valid;
    logic [PC_W-1:0] target;
  } if_redirect_t;

  // instruction handed to decode
  typedef struct packed {
    logic              valid;
    logic              err;
    logic [PC_W-1:0]   pc;
    logic [INST_W-1:0] inst;
  } if_fetch_t;

endpackage

// ==== if_fetch_buf.sv ====
`timescale 1ns/1ps

module if_fetch_buf
  import if_cpu_pkg::*;
  import if_axi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rd_done_i,
  input  logic [AXI_DATA_W-1:0] rd_data_i,
  input  axi_resp_e             rd_resp_i,
  input  logic                  drop_i,
  input  logic                  stall_i,
  input  logic [PC_W-1:0]       fetch_pc_i,
  output if_fetch_t             fetch_o
);

  // instruction waiting to be presented
  logic                  pend_q;
  logic                  err_q;
  logic [AXI_DATA_W-1:0] beat_q;

  logic              out_valid;
  logic [INST_W-1:0] half;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
      err_q  <= 1'b0;
    end else if (drop_i) begin
      // squashed beat, or a held inst younger than the redirect
      pend_q <= 1'b0;
    end else if (rd_done_i) begin
      pend_q <= 1'b1;
      err_q  <= (rd_resp_i != OKAY);
    end else if (out_valid) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_done_i && !drop_i) begin
      beat_q <= rd_data_i;
    end
  end

  // bit 2 picks the upper instruction of the doubleword
  assign half = fetch_pc_i[2] ? beat_q[63:32] : beat_q[31:0];

  // one valid cycle, the first one without stall
  assign out_valid = pend_q && !stall_i && !drop_i;

  always_comb begin
    fetch_o.valid = out_valid;
    fetch_o.err   = out_valid && err_q;
    fetch_o.pc    = fetch_pc_i;
    fetch_o.inst  = (out_valid && !err_q) ? half : NOP_INST;
  end

endmodule

// ==== if_fetch_ctrl.sv ====
`timescale 1ns/1ps

module if_fetch_ctrl
  import if_cpu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  if_redirect_t redirect_i,
  input  logic         stall_i,
  input  logic         rd_done_i,
  output logic         req_o,
  output logic         pc_adv_o,
  output logic         pc_load_o,
  output logic         drop_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;

  // redirect seen while a read was outstanding
  logic drop_q;
  // returned beat survives any redirect
  logic kept;

  // current or earlier redirect squashes the beat
  assign drop_o = drop_q || redirect_i.valid;
  assign kept   = rd_done_i && !drop_o;

  // no issue under stall
  // no issue in a redirect cycle either, pc still holds the old address
  assign req_o = (state_q == REQ) && !stall_i && !redirect_i.valid;

  // redirect always wins the pc
  assign pc_load_o = redirect_i.valid;

  // one advance per delivered instruction
  assign pc_adv_o = (state_q == WAIT) && kept;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (!stall_i) begin
          state_d = REQ;
        end
      end
      REQ: begin
        // stays here until the request goes out
        if (req_o) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (rd_done_i) begin
          if (drop_o) begin
            // beat thrown away, refetch from new pc
            state_d = REQ;
          end else if (stall_i) begin
            state_d = HOLD;
          end else begin
            state_d = REQ;
          end
        end
      end
      HOLD: begin
        // buffer presents the held inst in this same cycle
        if (!stall_i) begin
          state_d = REQ;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // mark the in-flight fetch as squashed until its beat shows up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_q <= 1'b0;
    end else if (rd_done_i) begin
      drop_q <= 1'b0;
    end else if ((state_q == WAIT) && redirect_i.valid) begin
      drop_q <= 1'b1;
    end
  end

endmodule

// ==== if_imem_slave.sv ====
`timescale 1ns/1ps

module if_imem_slave
  import if_axi_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  output axi_r_t  r_o,
  input  logic    r_ready_i
);

  // instruction image, two instructions per word
  logic [AXI_DATA_W-1:0] mem [IMEM_WORDS];

  initial begin
    $readmemh("imem.hex", mem);
  end

  logic                  busy_q;
  logic [IMEM_CNT_W-1:0] cnt_q;
  logic [IMEM_IDX_W-1:0] idx_q;
  logic                  in_range_q;

  logic [AXI_ADDR_W-1:0] offset;
  logic                  in_range;
  logic                  ar_fire;
  logic                  r_fire;

  // decode against the memory window
  assign offset   = ar_i.addr - IMEM_BASE;
  assign in_range = (ar_i.addr >= IMEM_BASE) && (offset < IMEM_BYTES);

  // ready only while idle, one read at a time
  assign ar_ready_o = !busy_q;
  assign ar_fire    = ar_i.valid && ar_ready_o;
  assign r_fire     = r_o.valid && r_ready_i;

  // latency counter down to zero, then beat is up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (ar_fire) begin
      busy_q <= 1'b1;
      cnt_q  <= IMEM_CNT_W'(IMEM_LAT - 1);
    end else if (r_fire) begin
      busy_q <= 1'b0;
    end else if (busy_q && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // captured address decode
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      idx_q      <= offset[IMEM_IDX_W+2:3];
      in_range_q <= in_range;
    end
  end

  // out of range gives zero data and SLVERR
  always_comb begin
    r_o.valid = busy_q && (cnt_q == '0);
    r_o.data  = in_range_q ? mem[idx_q] : '0;
    r_o.resp  = in_range_q ? OKAY : SLVERR;
    r_o.last  = 1'b1;
  end

endmodule

// ==== if_pc_gen.sv ====
`timescale 1ns/1ps

module if_pc_gen
  import if_cpu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            pc_adv_i,
  input  logic            pc_load_i,
  input  logic [PC_W-1:0] target_i,
  output logic [PC_W-1:0] pc_o,
  output logic [PC_W-1:0] fetch_pc_o
);

  // address of the next fetch
  logic [PC_W-1:0] pc_q;
  // address of the last delivered fetch
  logic [PC_W-1:0] fetch_pc_q;

  // load beats advance
  // no branch prediction, always pc + 4
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (pc_load_i) begin
      pc_q <= target_i;
    end else if (pc_adv_i) begin
      pc_q <= pc_q + PC_W'(4);
    end
  end

  // advance happens on the kept beat, so the old pc is the beat's own address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_pc_q <= RESET_PC;
    end else if (pc_adv_i) begin
      fetch_pc_q <= pc_q;
    end
  end

  assign pc_o       = pc_q;
  assign fetch_pc_o = fetch_pc_q;

endmodule

// ==== if_top.sv ====
`timescale 1ns/1ps

module if_top
  import if_cpu_pkg::*;
  import if_axi_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  if_redirect_t redirect_i,
  input  logic         stall_i,
  output if_fetch_t    fetch_o
);

  // control to datapath
  logic pc_adv;
  logic pc_load;
  logic req;
  logic drop;

  logic [PC_W-1:0] pc;
  logic [PC_W-1:0] fetch_pc;

  // master to control and buffer
  logic                  rd_done;
  logic [AXI_DATA_W-1:0] rd_data;
  axi_resp_e             rd_resp;

  // internal AXI read channels
  axi_ar_t ar;
  logic    ar_ready;
  axi_r_t  r;
  logic    r_ready;

  if_fetch_ctrl u_fetch_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .stall_i    (stall_i),
    .rd_done_i  (rd_done),
    .req_o      (req),
    .pc_adv_o   (pc_adv),
    .pc_load_o  (pc_load),
    .drop_o     (drop)
  );

  if_pc_gen u_pc_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_adv_i   (pc_adv),
    .pc_load_i  (pc_load),
    .target_i   (redirect_i.target),
    .pc_o       (pc),
    .fetch_pc_o (fetch_pc)
  );

  if_axi_rd_master u_axi_rd_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req),
    .addr_i     (pc),
    .ar_o       (ar),
    .ar_ready_i (ar_ready),
    .r_i        (r),
    .r_ready_o  (r_ready),
    .rd_done_o  (rd_done),
    .rd_data_o  (rd_data),
    .rd_resp_o  (rd_resp)
  );

  if_imem_slave u_imem_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_ready_i  (r_ready)
  );

  if_fetch_buf u_fetch_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_done_i  (rd_done),
    .rd_data_i  (rd_data),
    .rd_resp_i  (rd_resp),
    .drop_i     (drop),
    .stall_i    (stall_i),
    .fetch_pc_i (fetch_pc),
    .fetch_o    (fetch_o)
  );

endmodule

// ==== if_top_props.sv ====
`timescale 1ns/1ps

module if_top_props
  import if_cpu_pkg::*;
  import if_axi_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input axi_ar_t   ar_i,
  input logic      ar_ready_i,
  input axi_r_t    r_i,
  input logic      stall_i,
  input if_fetch_t fetch_i
);

  // count of failed assertions
  int unsigned fail_cnt = 0;

  // AR keeps valid and address until the slave takes it
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_i.valid && !ar_ready_i |=> ar_i.valid && $stable(ar_i.addr))
    else begin
      $error("AR valid or address changed before ready");
      fail_cnt++;
    end

  // single beat reads only
  r_last: assert property (@(posedge clk) disable iff (!rst_n)
    r_i.valid |-> r_i.last)
    else begin
      $error("R beat without last");
      fail_cnt++;
    end

  stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |-> !fetch_i.valid)
    else begin
      $error("fetch output valid under stall");
      fail_cnt++;
    end

  // bubbles carry a NOP
  nop_fill: assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_i.valid |-> fetch_i.inst == NOP_INST)
    else begin
      $error("invalid fetch output without NOP");
      fail_cnt++;
    end

endmodule

bind if_top if_top_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .ar_i       (ar),
  .ar_ready_i (ar_ready),
  .r_i        (r),
  .stall_i    (stall_i),
  .fetch_i    (fetch_o)
);

// ==== imem.hex ====
// one 64-bit word per line, from IMEM_BASE upward
// upper 8 digits: inst at offset +4, lower 8 digits: inst at offset +0
0020011300100093
0040021300300193
00310233002081b3
40208333004182b3
0020f3b30020e333
00209433001123b3
0020d4b30020c433
00a0051340208533
00c0061300b00593
00e0071300d00693
0ff7f79300f00793
00179813fff00813
0017d8930017f893
00002a0301000a37
008a2a2300ca2a83
00000b1301ca0b13
fe0b1ee300100b93
001b0b1300cb8bb3
00008067fe9ff0ef
00000c1300100c93
001c0c13019c5463
00000d1300a00d13
00100073000d8d93
0000006f00000013

// ==== tb.f ====
if_cpu_pkg.sv
if_axi_pkg.sv
if_fetch_ctrl.sv
if_pc_gen.sv
if_axi_rd_master.sv
if_imem_slave.sv
if_fetch_buf.sv
if_top.sv
if_top_props.sv
tb_if_top.sv

// ==== tb_if_top.sv ====
`timescale 1ns/1ps

module tb_if_top
  import if_cpu_pkg::*;
  import if_axi_pkg::*;
();

  logic         clk;
  logic         rst_n;
  if_redirect_t redirect;
  logic         stall;
  if_fetch_t    fetch;

  // reference image from the same file as the slave
  logic [AXI_DATA_W-1:0] model_mem [IMEM_WORDS];

  // next pc the stream should deliver
  logic [PC_W-1:0] exp_pc;
  int unsigned     stall_len;

  if_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect),
    .stall_i    (stall),
    .fetch_o    (fetch)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // instruction the memory should hold at pc
  // two per doubleword with bit 2 picking the upper one
  function automatic logic [INST_W-1:0] expected_inst(input logic [PC_W-1:0] pc);
    logic [PC_W-1:0]       offset;
    logic [AXI_DATA_W-1:0] word;
    offset = pc - IMEM_BASE;
    word   = model_mem[offset >> 3];
    if (pc[2]) begin
      return word[63:32];
    end
    return word[31:0];
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [PC_W-1:0] expected,
                             input logic [PC_W-1:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // bound assertions count their failures
  always @(negedge clk) begin
    if (i_dut.u_props.fail_cnt != 0) begin
      fail_now("a bound concurrent assertion failed");
    end
  end

  // drive point just after the rising edge
  task automatic drive_edge();
    @(posedge clk);
    #1;
  endtask

  // falling edge samples until an instruction is presented
  task automatic wait_fetch();
    int n;
    n = 0;
    @(negedge clk);
    while (!fetch.valid) begin
      n++;
      if (n > 50) begin
        fail_now("no valid fetch output within 50 cycles");
      end
      @(negedge clk);
    end
  endtask

  task automatic expect_fetch(input logic [PC_W-1:0] pc, input logic [INST_W-1:0] inst,
                              input logic err);
    wait_fetch();
    check_value("fetch_o.pc", pc, fetch.pc);
    check_value("fetch_o.inst", inst, fetch.inst);
    check_value("fetch_o.err", err, fetch.err);
  endtask

  // one cycle pulse
  // nothing may come out in that cycle
  task automatic send_redirect(input logic [PC_W-1:0] target);
    drive_edge();
    redirect.valid  = 1'b1;
    redirect.target = target;
    @(negedge clk);
    check_value("fetch_o.valid", 1'b0, fetch.valid);
    drive_edge();
    redirect.valid = 1'b0;
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_value("fetch_o.valid", 1'b0, fetch.valid);
    check_value("fetch_o.inst", NOP_INST, fetch.inst);
    drive_edge();
    rst_n = 1'b1;
    @(negedge clk);
    check_value("fetch_o.valid", 1'b0, fetch.valid);
    check_value("fetch_o.inst", NOP_INST, fetch.inst);
    expect_fetch(RESET_PC, expected_inst(RESET_PC), 1'b0);
    exp_pc = RESET_PC + 64'd4;
  endtask

  task automatic test_sequential();
    for (int i = 0; i < 10; i++) begin
      expect_fetch(exp_pc, expected_inst(exp_pc), 1'b0);
      exp_pc = exp_pc + 64'd4;
    end
  endtask

  task automatic test_stall();
    // successor of this one is in flight when stall rises
    expect_fetch(exp_pc, expected_inst(exp_pc), 1'b0);
    exp_pc    = exp_pc + 64'd4;
    stall_len = 3 + ($urandom % 8);
    drive_edge();
    stall = 1'b1;
    repeat (stall_len) begin
      @(negedge clk);
      check_value("fetch_o.valid", 1'b0, fetch.valid);
    end
    drive_edge();
    stall = 1'b0;
    // held inst first and then the stream carries on
    for (int i = 0; i < 2; i++) begin
      expect_fetch(exp_pc, expected_inst(exp_pc), 1'b0);
      exp_pc = exp_pc + 64'd4;
    end
  endtask

  task automatic test_redirect();
    expect_fetch(exp_pc, expected_inst(exp_pc), 1'b0);
    // upper half of a doubleword as target
    exp_pc = IMEM_BASE + 64'h84;
    send_redirect(exp_pc);
    for (int i = 0; i < 3; i++) begin
      expect_fetch(exp_pc, expected_inst(exp_pc), 1'b0);
      exp_pc = exp_pc + 64'd4;
    end
  endtask

  task automatic test_error();
    logic [PC_W-1:0] bad_pc;
    expect_fetch(exp_pc, expected_inst(exp_pc), 1'b0);
    // first byte past the memory end
    bad_pc = IMEM_BASE + 64'(8 * IMEM_WORDS);
    send_redirect(bad_pc);
    expect_fetch(bad_pc, NOP_INST, 1'b1);
  endtask

  initial begin
    rst_n    = 1'b0;
    stall    = 1'b0;
    redirect = '0;
    exp_pc   = RESET_PC;
    void'($urandom(32'heab2));
    $readmemh("imem.hex", model_mem);
    test_reset();
    test_sequential();
    test_stall();
    test_redirect();
    test_error();
    drive_edge();
    if (i_dut.u_props.fail_cnt == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_now($sformatf("concurrent assertion failures: %0d", i_dut.u_props.fail_cnt));
    end
  end

endmodule
